//--- scaler_pkg.sv
`default_nettype none

package scaler_pkg;

    localparam int pixel_width = 12;
    // a weight of 512 is unity gain.
    localparam int coeff_width = 10;
    localparam int table_input_width = 10;
    localparam int phase_width = 24;
    localparam int mul_width = pixel_width + coeff_width;

    typedef logic [pixel_width-1:0] pixel_t;
    // 4.12 unsigned, 4096 is 1.0.
    typedef logic [15:0] scale_step_t;
    typedef logic [phase_width-1:0] phase_t;
    typedef logic [coeff_width-1:0] coeff_t;
    typedef logic [9:0] table_addr_t;

    localparam phase_t pixel_step = phase_t'(4096);
    localparam int round_adder = 256;
    localparam pixel_t max_pixel = pixel_t'(4095);
    localparam coeff_t coeff_one = coeff_t'(512);
    // keeps the top table_input_width address bits.
    localparam table_addr_t table_addr_mask = table_addr_t'(
        ((1 << table_input_width) - 1) << ($bits(table_addr_t) - table_input_width));

    typedef struct packed {
        pixel_t data;
        logic   dv;
        logic   hs;
        logic   vs;
    } video_beat_t;

    // m0 is the newest pixel, m3 the oldest.
    typedef struct packed {
        pixel_t m3;
        pixel_t m2;
        pixel_t m1;
        pixel_t m0;
    } tap_set_t;

    typedef struct packed {
        coeff_t f3;
        coeff_t f2;
        coeff_t f1;
        coeff_t f0;
    } coeff_set_t;

    typedef struct packed {
        logic pick;
        logic line;
        logic frame;
    } pick_t;

endpackage

`default_nettype wire

//--- phase_accumulator.sv
`timescale 1ns/1ns
`default_nettype none

module phase_accumulator (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire scaler_pkg::video_beat_t in_beat,
    input  wire scaler_pkg::scale_step_t scale_step,
    output scaler_pkg::pick_t            pick_q,
    output scaler_pkg::table_addr_t      table_addr,
    output logic                         first_taps,
    output logic                         pick_now
);

    scaler_pkg::phase_t in_phase;
    scaler_pkg::phase_t out_phase;
    logic               line_pending;
    logic               frame_pending;
    logic               line_start;

    // an output pixel is due once the input has moved past its position.
    assign pick_now = in_phase > out_phase;

    assign line_start = in_beat.dv && in_beat.hs;

    // left edge of the line, the oldest tap is not real yet.
    assign first_taps = in_phase <= 2 * scaler_pkg::pixel_step;

    // fractional part of the output position, quarter resolution.
    assign table_addr = out_phase[11:2] & scaler_pkg::table_addr_mask;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_phase      <= '0;
            out_phase     <= '0;
            line_pending  <= 1'b0;
            frame_pending <= 1'b0;
            pick_q        <= '0;
        end else begin
            pick_q <= '0;

            if (in_beat.dv) begin
                in_phase <= in_phase + scaler_pkg::pixel_step;
            end

            if (pick_now) begin
                out_phase    <= out_phase + scaler_pkg::phase_t'(scale_step);
                pick_q.pick  <= 1'b1;
                pick_q.line  <= line_pending;
                pick_q.frame <= frame_pending;
                // the markers travel with the first pick after they were seen.
                if (line_pending) begin
                    line_pending <= 1'b0;
                end
                if (frame_pending) begin
                    frame_pending <= 1'b0;
                end
            end

            // a marker seen now waits for the next pick.
            if (in_beat.dv) begin
                if (in_beat.hs) begin
                    line_pending <= 1'b1;
                end
                if (in_beat.vs) begin
                    frame_pending <= 1'b1;
                end
            end

            // new line restarts both positions, output one pixel behind.
            if (line_start) begin
                in_phase  <= '0;
                out_phase <= scaler_pkg::pixel_step;
            end
        end
    end

    // line and frame markers only ever ride on a pick.
    assert property (@(posedge clk) disable iff (!arst_n)
        (pick_q.line || pick_q.frame) |-> pick_q.pick);

endmodule

`default_nettype wire

//--- tap_window.sv
`timescale 1ns/1ns
`default_nettype none

module tap_window (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire scaler_pkg::video_beat_t in_beat,
    input  wire                          pick,
    input  wire                          first_taps,
    output scaler_pkg::tap_set_t         taps
);

    // last four valid input pixels.
    scaler_pkg::tap_set_t window;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            window <= '0;
        end else if (in_beat.dv) begin
            window.m3 <= window.m2;
            window.m2 <= window.m1;
            window.m1 <= window.m0;
            window.m0 <= in_beat.data;
        end
    end

    always_ff @(posedge clk) begin
        if (pick) begin
            taps.m0 <= window.m0;
            taps.m1 <= window.m1;
            taps.m2 <= window.m2;
            // oldest tap still belongs to the previous line here.
            taps.m3 <= first_taps ? '0 : window.m3;
        end
    end

endmodule

`default_nettype wire

//--- cubic_table.sv
`timescale 1ns/1ns
`default_nettype none

module cubic_table (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire scaler_pkg::table_addr_t table_addr,
    output scaler_pkg::coeff_set_t       coeffs
);

    // powers of the address scaled to a common 2^30 base.
    logic [35:0] lin;
    logic [35:0] sq;
    logic [35:0] cube;
    logic [35:0] n0;
    logic [35:0] n1;
    logic [35:0] n2;
    logic [35:0] n3;
    scaler_pkg::coeff_set_t weights;
    logic signed [11:0] unity;

    always_comb begin
        lin  = 36'(table_addr) << 20;
        sq   = (36'(table_addr) * 36'(table_addr)) << 10;
        cube = 36'(table_addr) * 36'(table_addr) * 36'(table_addr);

        // each numerator is non-negative on [0, 1), wrap in between is harmless.
        n0 = lin - 2 * sq + cube;
        n1 = 36'h0_8000_0000 - 5 * sq + 3 * cube;
        n2 = lin + 4 * sq - 3 * cube;
        n3 = sq - cube;

        // 256 / 2^30 leaves a shift by 22.
        weights.f0 = scaler_pkg::coeff_t'(n0 >> 22);
        weights.f1 = scaler_pkg::coeff_t'(n1 >> 22);
        weights.f2 = scaler_pkg::coeff_t'(n2 >> 22);
        weights.f3 = scaler_pkg::coeff_t'(n3 >> 22);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            coeffs    <= '0;
            coeffs.f1 <= scaler_pkg::coeff_one;
        end else begin
            coeffs <= weights;
        end
    end

    assign unity = $signed({2'b00, coeffs.f1}) + $signed({2'b00, coeffs.f2})
                 - $signed({2'b00, coeffs.f0}) - $signed({2'b00, coeffs.f3});

    // truncation error of four weights, the gain stays near unity.
    assert property (@(posedge clk) disable iff (!arst_n)
        unity >= 12'sd508 && unity <= 12'sd516);

endmodule

`default_nettype wire

//--- cubic_filter.sv
`timescale 1ns/1ns
`default_nettype none

module cubic_filter (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire scaler_pkg::tap_set_t   taps,
    input  wire scaler_pkg::coeff_set_t coeffs,
    input  wire scaler_pkg::pick_t      pick_q,
    output scaler_pkg::video_beat_t     out_beat
);

    typedef logic signed [scaler_pkg::mul_width+1:0] sum_t;

    logic [scaler_pkg::mul_width-1:0] mul0;
    logic [scaler_pkg::mul_width-1:0] mul1;
    logic [scaler_pkg::mul_width-1:0] mul2;
    logic [scaler_pkg::mul_width-1:0] mul3;
    sum_t                             sum;
    scaler_pkg::pixel_t               clamped;
    scaler_pkg::pick_t                pick_d1;
    scaler_pkg::pick_t                pick_d2;

    always_ff @(posedge clk) begin
        mul0 <= coeffs.f0 * taps.m0;
        mul1 <= coeffs.f1 * taps.m1;
        mul2 <= coeffs.f2 * taps.m2;
        mul3 <= coeffs.f3 * taps.m3;

        // outer taps carry the negative lobes.
        sum <= sum_t'(mul1) + sum_t'(mul2)
             - sum_t'(mul0) - sum_t'(mul3)
             + sum_t'(scaler_pkg::round_adder);
    end

    always_comb begin
        if (sum < 0) begin
            clamped = '0;
        end else if (sum[scaler_pkg::mul_width] || sum[scaler_pkg::mul_width-1]) begin
            clamped = scaler_pkg::max_pixel;
        end else begin
            clamped = sum[scaler_pkg::coeff_width-1 +: scaler_pkg::pixel_width];
        end
    end

    // sync follows the data through products and sum.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pick_d1  <= '0;
            pick_d2  <= '0;
            out_beat <= '0;
        end else begin
            pick_d1     <= pick_q;
            pick_d2     <= pick_d1;
            out_beat.dv <= pick_d2.pick;
            out_beat.hs <= pick_d2.line;
            out_beat.vs <= pick_d2.frame;
            if (pick_d2.pick) begin
                out_beat.data <= clamped;
            end
        end
    end

    // a line start is always carried by a real output pixel.
    assert property (@(posedge clk) disable iff (!arst_n)
        out_beat.hs |-> out_beat.dv);

endmodule

`default_nettype wire

//--- scaler_horizontal.sv
`timescale 1ns/1ns
`default_nettype none

module scaler_horizontal (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire scaler_pkg::video_beat_t in_beat,
    input  wire scaler_pkg::scale_step_t scale_step,
    output scaler_pkg::video_beat_t      out_beat
);

    scaler_pkg::pick_t       pick_q;
    scaler_pkg::table_addr_t table_addr;
    logic                    first_taps;
    logic                    pick_now;
    scaler_pkg::tap_set_t    taps;
    scaler_pkg::coeff_set_t  coeffs;

    phase_accumulator phase_accumulator_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_beat    (in_beat),
        .scale_step (scale_step),
        .pick_q     (pick_q),
        .table_addr (table_addr),
        .first_taps (first_taps),
        .pick_now   (pick_now)
    );

    // taps are captured on the same edge that registers pick_q.
    tap_window tap_window_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_beat    (in_beat),
        .pick       (pick_now),
        .first_taps (first_taps),
        .taps       (taps)
    );

    cubic_table cubic_table_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .table_addr (table_addr),
        .coeffs     (coeffs)
    );

    cubic_filter cubic_filter_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .taps     (taps),
        .coeffs   (coeffs),
        .pick_q   (pick_q),
        .out_beat (out_beat)
    );

endmodule

`default_nettype wire

//--- tb_scaler_horizontal.sv
`timescale 1ns/1ns
`default_nettype none

module tb_scaler_horizontal;

    typedef struct packed {
        scaler_pkg::video_beat_t beat;
        int                      due;
    } expect_t;

    logic                    clk;
    logic                    arst_n;
    scaler_pkg::video_beat_t in_beat;
    scaler_pkg::scale_step_t scale_step;
    scaler_pkg::video_beat_t out_beat;

    int                      cycle_count;
    int                      checked_count;
    expect_t                 expect_q[$];
    // reference model state, advanced on the rising edge.
    scaler_pkg::phase_t      model_in_phase;
    scaler_pkg::phase_t      model_out_phase;
    logic                    model_line;
    logic                    model_frame;
    scaler_pkg::tap_set_t    model_window;

    scaler_horizontal dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_beat    (in_beat),
        .scale_step (scale_step),
        .out_beat   (out_beat)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input scaler_pkg::pixel_t got,
                               input scaler_pkg::pixel_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s got 0x%03h expected 0x%03h at cycle %0d",
                                name, got, exp, cycle_count));
        end
    endtask

    task automatic check_sync(input scaler_pkg::video_beat_t got,
                              input scaler_pkg::video_beat_t exp);
        if (got.hs !== exp.hs) begin
            abort_run($sformatf("FAILED out_beat.hs got 0x%0h expected 0x%0h at cycle %0d",
                                got.hs, exp.hs, cycle_count));
        end
        if (got.vs !== exp.vs) begin
            abort_run($sformatf("FAILED out_beat.vs got 0x%0h expected 0x%0h at cycle %0d",
                                got.vs, exp.vs, cycle_count));
        end
    endtask

    task automatic check_cycle(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // t = addr / 1024, each weight is 256 * p(t) truncated toward zero.
    function automatic scaler_pkg::coeff_set_t catmull_rom_weights(
        input scaler_pkg::table_addr_t addr);
        longint a;
        longint d;
        longint d3;
        scaler_pkg::coeff_set_t w;
        a  = longint'(addr);
        d  = 1024;
        d3 = d * d * d;
        w.f0 = scaler_pkg::coeff_t'(256 * (a * d * d - 2 * a * a * d + a * a * a) / d3);
        w.f1 = scaler_pkg::coeff_t'(256 * (2 * d3 - 5 * a * a * d + 3 * a * a * a) / d3);
        w.f2 = scaler_pkg::coeff_t'(256 * (a * d * d + 4 * a * a * d - 3 * a * a * a) / d3);
        w.f3 = scaler_pkg::coeff_t'(256 * (a * a * d - a * a * a) / d3);
        return w;
    endfunction

    function automatic scaler_pkg::pixel_t expected_pixel(input scaler_pkg::tap_set_t w,
                                                          input logic left_edge,
                                                          input scaler_pkg::phase_t phase);
        scaler_pkg::coeff_set_t c;
        longint oldest;
        longint acc;
        c = catmull_rom_weights(phase[11:2]);
        oldest = left_edge ? 0 : longint'(w.m3);
        acc = longint'(c.f1) * longint'(w.m1) + longint'(c.f2) * longint'(w.m2)
            - longint'(c.f0) * longint'(w.m0) - longint'(c.f3) * oldest + 256;
        if (acc < 0) begin
            return '0;
        end else if (acc >= (longint'(1) << 21)) begin
            return scaler_pkg::pixel_t'(4095);
        end else begin
            return scaler_pkg::pixel_t'(acc / 512);
        end
    endfunction

    function automatic scaler_pkg::scale_step_t pick_step(input int kind);
        case (kind)
            0: return 16'd4096;
            1: return 16'd2048;
            2: return 16'd3000;
            3: return 16'd6144;
            default: return scaler_pkg::scale_step_t'($urandom_range(2048, 8192));
        endcase
    endfunction

    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            in_beat.data = scaler_pkg::pixel_t'($urandom_range(0, 4095));
            in_beat.dv = 1'b0;
            in_beat.hs = 1'b0;
            in_beat.vs = 1'b0;
        end
    endtask

    task automatic drive_line(input int length, input logic with_vs, input logic alternating);
        scaler_pkg::video_beat_t beat;
        for (int i = 0; i < length; i++) begin
            // occasional hole inside the line.
            if ($urandom_range(0, 5) == 0) begin
                idle_cycles(1);
            end
            if (alternating) begin
                // pairs of full scale and zero make the cubic ring past both rails.
                beat.data = (i % 4 < 2) ? scaler_pkg::pixel_t'(4095) : '0;
            end else begin
                beat.data = scaler_pkg::pixel_t'($urandom_range(0, 4095));
            end
            beat.dv = 1'b1;
            beat.hs = (i == 0);
            beat.vs = (i == 0) && with_vs;
            @(negedge clk);
            in_beat = beat;
        end
    endtask

    always @(posedge clk) begin
        logic    pick;
        expect_t item;
        cycle_count = cycle_count + 1;
        if (!arst_n) begin
            model_in_phase  = '0;
            model_out_phase = '0;
            model_line      = 1'b0;
            model_frame     = 1'b0;
            model_window    = '0;
        end else begin
            pick = model_in_phase > model_out_phase;
            if (pick) begin
                item.beat.data = expected_pixel(model_window, model_in_phase <= 8192,
                                                model_out_phase);
                item.beat.dv = 1'b1;
                item.beat.hs = model_line;
                item.beat.vs = model_frame;
                // output registers three edges after the pick.
                item.due = cycle_count + 3;
                expect_q.push_back(item);
                model_out_phase = model_out_phase + scaler_pkg::phase_t'(scale_step);
                model_line  = 1'b0;
                model_frame = 1'b0;
            end
            if (in_beat.dv) begin
                model_in_phase = model_in_phase + 4096;
                model_window.m3 = model_window.m2;
                model_window.m2 = model_window.m1;
                model_window.m1 = model_window.m0;
                model_window.m0 = in_beat.data;
                if (in_beat.hs) begin
                    model_line      = 1'b1;
                    model_in_phase  = '0;
                    model_out_phase = 4096;
                end
                if (in_beat.vs) begin
                    model_frame = 1'b1;
                end
            end
        end
    end

    always @(negedge clk) begin
        expect_t item;
        if (out_beat.dv === 1'b1) begin
            if (expect_q.size() == 0) begin
                abort_run("an output pixel appeared while none was expected");
            end else begin
                item = expect_q.pop_front();
                check_cycle("out_beat.dv cycle", cycle_count, item.due);
                check_pixel("out_beat.data", out_beat.data, item.beat.data);
                check_sync(out_beat, item.beat);
                checked_count = checked_count + 1;
            end
        end else if (out_beat.dv !== 1'b0) begin
            abort_run("out_beat.dv is unknown");
        end else begin
            check_sync(out_beat, '0);
            if (expect_q.size() != 0 && expect_q[0].due <= cycle_count) begin
                abort_run($sformatf("the output pixel due at cycle %0d never appeared",
                                    expect_q[0].due));
            end
        end
    end

    initial begin
        int step_kind;
        int line_length;
        int drain_wait;
        void'($urandom(67));
        clk         = 1'b0;
        arst_n      = 1'b0;
        in_beat     = '0;
        scale_step  = 16'd4096;
        cycle_count = 0;
        checked_count = 0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        idle_cycles(10);

        for (int frame = 0; frame < 12; frame++) begin
            step_kind = (frame < 5) ? frame : int'($urandom_range(0, 4));
            @(negedge clk);
            scale_step = pick_step(step_kind);
            idle_cycles(4);
            for (int line = 0; line < 4; line++) begin
                line_length = $urandom_range(40, 120);
                drive_line(line_length, line == 0, line == 2);
                // gap long enough for an enlarged line to drain.
                idle_cycles(2 * line_length + $urandom_range(3, 20));
            end
        end

        drain_wait = 0;
        while (expect_q.size() != 0 && drain_wait < 500) begin
            @(negedge clk);
            drain_wait++;
        end
        idle_cycles(8);
        if (expect_q.size() != 0) begin
            abort_run($sformatf("timed out with %0d expected output pixels still missing",
                                expect_q.size()));
        end else begin
            $display("%0d output pixels checked", checked_count);
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- compile.f
scaler_pkg.sv
phase_accumulator.sv
tap_window.sv
cubic_table.sv
cubic_filter.sv
scaler_horizontal.sv
tb_scaler_horizontal.sv

//--- Makefile
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_scaler_horizontal: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_scaler_horizontal -f compile.f

run: obj_dir/Vtb_scaler_horizontal
	./obj_dir/Vtb_scaler_horizontal

clean:
	rm -rf obj_dir
